/* list.f */
logic/buffbypass_cfg_pkg.sv
logic/buffbypass_types_pkg.sv
logic/bit_synchronizer.sv
logic/reset_inv_synchronizer.sv
logic/buffbypass_start_detect.sv
logic/buffbypass_tx_sequencer.sv
logic/buffbypass_tx_top.sv
verif/gt_txphase_model.sv
verif/tb_buffbypass_tx.sv

/* logic/bit_synchronizer.sv */
`timescale 1ns/1ps

module bit_synchronizer import buffbypass_cfg_pkg::*; #(
        parameter int P_STAGES = C_SYNC_STAGES
) (
        input  logic clk,
        input  logic i,
        output logic o
);

        // The chain powers up cleared and shifts one stage per edge
        logic [P_STAGES-1:0] sync_q = '0;

        always_ff @(posedge clk) begin
                if (P_STAGES > 1) begin
                        sync_q <= {sync_q[P_STAGES-2:0], i};
                end else begin
                        sync_q[0] <= i;
                end
        end

        // Oldest stage drives the output, so o follows i after P_STAGES edges
        assign o = sync_q[P_STAGES-1];

endmodule

/* logic/buffbypass_cfg_pkg.sv */
package buffbypass_cfg_pkg;

        // Number of transceiver lanes served by one controller
        localparam int C_NUM_CHANNELS = 4;

        // Lane whose sync-done and phase-align-done decide the outcome of the procedure
        // Must be below C_NUM_CHANNELS
        localparam int C_MASTER_CHANNEL = 1;

        // Depth of the flop chain that brings transceiver status into the controller clock
        // Five stages leave margin for the slow phase alignment outputs
        localparam int C_SYNC_STAGES = 5;

endpackage

/* logic/buffbypass_start_detect.sv */
`timescale 1ns/1ps

module buffbypass_start_detect (
        input  logic gtwiz_buffbypass_tx_clk_in,
        input  logic gtwiz_buffbypass_tx_reset_in,
        input  logic resetdone,
        input  logic start_user,
        output logic start
);

        logic resetdone_sync;
        logic resetdone_q;

        // Reset-done falls immediately and rises two cycles late
        reset_inv_synchronizer u_resetdone_sync (
                .clk      (gtwiz_buffbypass_tx_clk_in),
                .rst      (resetdone),
                .rst_sync (resetdone_sync)
        );

        // Previous value of the synchronized level, for edge detection
        always_ff @(posedge gtwiz_buffbypass_tx_clk_in) begin
                if (gtwiz_buffbypass_tx_reset_in) begin
                        resetdone_q <= 1'b0;
                end else begin
                        resetdone_q <= resetdone_sync;
                end
        end

        // A fresh reset-done or a user request both start the procedure
        // The strobe from the user is passed through without a register
        assign start = (resetdone_sync & ~resetdone_q) | start_user;

endmodule

/* logic/buffbypass_tx_sequencer.sv */
`timescale 1ns/1ps

module buffbypass_tx_sequencer import buffbypass_cfg_pkg::*, buffbypass_types_pkg::*; #(
        parameter int P_TOTAL_NUMBER_OF_CHANNELS = C_NUM_CHANNELS,
        parameter int P_MASTER_CHANNEL_POINTER   = C_MASTER_CHANNEL,
        parameter int P_STAGES                   = C_SYNC_STAGES
) (
        input  logic               gtwiz_buffbypass_tx_clk_in,
        input  logic               gtwiz_buffbypass_tx_reset_in,
        input  logic               start,
        input  tx_lane_stat_t      lane_stat [P_TOTAL_NUMBER_OF_CHANNELS],
        output tx_lane_ctrl_t      lane_ctrl [P_TOTAL_NUMBER_OF_CHANNELS],
        output buffbypass_status_t status
);

        typedef enum logic [1:0] {
                ST_IDLE          = 2'd0,
                ST_DEASSERT_SRST = 2'd1,
                ST_WAIT_SYNCDONE = 2'd2,
                ST_DONE          = 2'd3
        } bypass_state_t;

        bypass_state_t      state_q;
        logic               dlysreset_q;
        buffbypass_status_t status_q;

        logic               master_syncdone_sync;
        logic               master_syncdone_q;
        logic               master_syncdone_rise;
        logic               master_phaligndone_sync;
        logic               all_phaligndone;

        // Master lane status enters the controller clock through separate chains
        bit_synchronizer #(
                .P_STAGES (P_STAGES)
        ) u_syncdone_sync (
                .clk (gtwiz_buffbypass_tx_clk_in),
                .i   (lane_stat[P_MASTER_CHANNEL_POINTER].syncdone),
                .o   (master_syncdone_sync)
        );

        bit_synchronizer #(
                .P_STAGES (P_STAGES)
        ) u_phaligndone_sync (
                .clk (gtwiz_buffbypass_tx_clk_in),
                .i   (lane_stat[P_MASTER_CHANNEL_POINTER].phaligndone),
                .o   (master_phaligndone_sync)
        );

        always_ff @(posedge gtwiz_buffbypass_tx_clk_in) begin
                if (gtwiz_buffbypass_tx_reset_in) begin
                        master_syncdone_q <= 1'b0;
                end else begin
                        master_syncdone_q <= master_syncdone_sync;
                end
        end

        // Only a rising edge counts, a level left over from the last run must not end the wait
        assign master_syncdone_rise = master_syncdone_sync & ~master_syncdone_q;

        always_ff @(posedge gtwiz_buffbypass_tx_clk_in) begin
                if (gtwiz_buffbypass_tx_reset_in) begin
                        state_q     <= ST_IDLE;
                        dlysreset_q <= 1'b0;
                        status_q    <= '0;
                end else begin
                        case (state_q)
                        ST_IDLE: begin
                                // Start pulses seen in any other state are dropped
                                if (start) begin
                                        dlysreset_q <= 1'b1;
                                        status_q    <= '0;
                                        state_q     <= ST_DEASSERT_SRST;
                                end
                        end
                        ST_DEASSERT_SRST: begin
                                dlysreset_q <= 1'b0;
                                state_q     <= ST_WAIT_SYNCDONE;
                        end
                        ST_WAIT_SYNCDONE: begin
                                if (master_syncdone_rise) begin
                                        state_q <= ST_DONE;
                                end
                        end
                        ST_DONE: begin
                                // Alignment that finished without phase-align-done is a failure
                                status_q.done  <= 1'b1;
                                status_q.error <= ~master_phaligndone_sync;
                                state_q        <= ST_IDLE;
                        end
                        default: begin
                                state_q <= ST_IDLE;
                        end
                        endcase
                end
        end

        assign status = status_q;

        // All lanes must report phase alignment before any of them may finish sync
        always_comb begin
                all_phaligndone = 1'b1;
                for (int li = 0; li < P_TOTAL_NUMBER_OF_CHANNELS; li++) begin
                        all_phaligndone &= lane_stat[li].phaligndone;
                end
        end

        for (genvar gi = 0; gi < P_TOTAL_NUMBER_OF_CHANNELS; gi++) begin : g_lane
                always_comb begin
                        // Every manual-mode control is tied low in auto mode
                        lane_ctrl[gi]           = '0;
                        lane_ctrl[gi].syncmode  = (gi == P_MASTER_CHANNEL_POINTER);
                        lane_ctrl[gi].syncallin = all_phaligndone;
                        lane_ctrl[gi].dlysreset = dlysreset_q;
                        // A single lane has no master to follow
                        if (P_TOTAL_NUMBER_OF_CHANNELS > 1) begin
                                lane_ctrl[gi].syncin = lane_stat[P_MASTER_CHANNEL_POINTER].syncout;
                        end
                end
        end

endmodule

/* logic/buffbypass_tx_top.sv */
`timescale 1ns/1ps

module buffbypass_tx_top import buffbypass_cfg_pkg::*, buffbypass_types_pkg::*; #(
        parameter int P_TOTAL_NUMBER_OF_CHANNELS = C_NUM_CHANNELS,
        parameter int P_MASTER_CHANNEL_POINTER   = C_MASTER_CHANNEL,
        parameter int P_STAGES                   = C_SYNC_STAGES
) (
        input  logic               gtwiz_buffbypass_tx_clk_in,
        input  logic               gtwiz_buffbypass_tx_reset_in,
        input  logic               resetdone,
        input  logic               start_user,
        input  tx_lane_stat_t      lane_stat [P_TOTAL_NUMBER_OF_CHANNELS],
        output tx_lane_ctrl_t      lane_ctrl [P_TOTAL_NUMBER_OF_CHANNELS],
        output buffbypass_status_t status
);

        // One-cycle request from the start detector to the state machine
        logic start;

        buffbypass_start_detect u_start_detect (
                .gtwiz_buffbypass_tx_clk_in   (gtwiz_buffbypass_tx_clk_in),
                .gtwiz_buffbypass_tx_reset_in (gtwiz_buffbypass_tx_reset_in),
                .resetdone                    (resetdone),
                .start_user                   (start_user),
                .start                        (start)
        );

        buffbypass_tx_sequencer #(
                .P_TOTAL_NUMBER_OF_CHANNELS (P_TOTAL_NUMBER_OF_CHANNELS),
                .P_MASTER_CHANNEL_POINTER   (P_MASTER_CHANNEL_POINTER),
                .P_STAGES                   (P_STAGES)
        ) u_sequencer (
                .gtwiz_buffbypass_tx_clk_in   (gtwiz_buffbypass_tx_clk_in),
                .gtwiz_buffbypass_tx_reset_in (gtwiz_buffbypass_tx_reset_in),
                .start                        (start),
                .lane_stat                    (lane_stat),
                .lane_ctrl                    (lane_ctrl),
                .status                       (status)
        );

endmodule

/* logic/buffbypass_types_pkg.sv */
package buffbypass_types_pkg;

        // Controls driven toward one transceiver lane
        // In auto mode only syncmode, syncallin, syncin and dlysreset ever carry information
        typedef struct packed {
                logic phdlyreset;
                logic phalign;
                logic phalignen;
                logic phdlypd;
                logic phinit;
                logic phovrden;
                logic dlybypass;
                logic dlyen;
                logic dlyovrden;
                logic phdlytstclk;
                logic dlyhold;
                logic dlyupdown;
                logic syncmode;
                logic syncallin;
                logic syncin;
                logic dlysreset;
        } tx_lane_ctrl_t;

        // Status returned by one transceiver lane, asynchronous to the controller clock
        typedef struct packed {
                logic phaligndone;
                logic syncdone;
                logic syncout;
        } tx_lane_stat_t;

        // Result of the bypass procedure as seen by the user
        // error is only meaningful while done is high
        typedef struct packed {
                logic done;
                logic error;
        } buffbypass_status_t;

endpackage

/* logic/reset_inv_synchronizer.sv */
`timescale 1ns/1ps

module reset_inv_synchronizer (
        input  logic clk,
        input  logic rst,
        output logic rst_sync
);

        logic [1:0] chain_q;

        // A low level on rst clears the chain at once
        // A high level walks in through both flops before it is seen
        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        chain_q <= 2'b00;
                end else begin
                        chain_q <= {chain_q[0], 1'b1};
                end
        end

        assign rst_sync = chain_q[1];

endmodule

/* run.sh */
#!/usr/bin/env bash
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -f list.f --top-module tb_buffbypass_tx -Mdir obj_dir &&
./obj_dir/Vtb_buffbypass_tx | tee /dev/stderr | grep -x -F "=== PASS ===" > /dev/null &&
{ echo "Simulation passed"; exit 0; } ||
{ echo "Simulation failed"; exit 1; }

/* verif/gt_txphase_model.sv */
`timescale 1ns/1ps

module gt_txphase_model import buffbypass_cfg_pkg::*, buffbypass_types_pkg::*; #(
        parameter int P_TOTAL_NUMBER_OF_CHANNELS = C_NUM_CHANNELS,
        parameter int P_MASTER_CHANNEL_POINTER   = C_MASTER_CHANNEL,
        parameter int P_SYNC_GAP                 = 3
) (
        input  logic                                  clk,
        input  tx_lane_ctrl_t                         lane_ctrl [P_TOTAL_NUMBER_OF_CHANNELS],
        input  logic                                  withhold_master_phaligndone,
        input  logic [P_TOTAL_NUMBER_OF_CHANNELS-1:0] lane_force_low,
        output tx_lane_stat_t                         lane_stat [P_TOTAL_NUMBER_OF_CHANNELS]
);

        int   seed         = 32'hbde4_1cec;
        int   phase_delay  = 0;
        int   cycle_cnt    = 0;
        logic running      = 1'b0;
        logic phase_done_q = 1'b0;
        logic sync_done_q  = 1'b0;

        // Each dlysreset pulse restarts the alignment with a new random duration
        // Sync-done follows phase-align-done after a fixed gap
        always @(posedge clk) begin
                if (lane_ctrl[P_MASTER_CHANNEL_POINTER].dlysreset) begin
                        phase_delay  <= 4 + ($unsigned($random(seed)) % 16);
                        cycle_cnt    <= 0;
                        running      <= 1'b1;
                        phase_done_q <= 1'b0;
                        sync_done_q  <= 1'b0;
                end else if (running) begin
                        cycle_cnt <= cycle_cnt + 1;
                        if (cycle_cnt >= phase_delay) begin
                                phase_done_q <= 1'b1;
                        end
                        if (cycle_cnt >= phase_delay + P_SYNC_GAP) begin
                                sync_done_q <= 1'b1;
                                running     <= 1'b0;
                        end
                end
        end

        for (genvar gi = 0; gi < P_TOTAL_NUMBER_OF_CHANNELS; gi++) begin : g_lane
                always_comb begin
                        lane_stat[gi].phaligndone = phase_done_q & ~lane_force_low[gi];
                        // The master lane can be told to never report phase alignment
                        if ((gi == P_MASTER_CHANNEL_POINTER) && withhold_master_phaligndone) begin
                                lane_stat[gi].phaligndone = 1'b0;
                        end
                        // Only the master lane reports sync, slaves keep these low
                        lane_stat[gi].syncdone = (gi == P_MASTER_CHANNEL_POINTER) & sync_done_q
                                                 & ~lane_force_low[gi];
                        lane_stat[gi].syncout  = (gi == P_MASTER_CHANNEL_POINTER) & sync_done_q
                                                 & ~lane_force_low[gi];
                end
        end

endmodule

/* verif/tb_buffbypass_tx.sv */
`timescale 1ns/1ps

module tb_buffbypass_tx import buffbypass_cfg_pkg::*, buffbypass_types_pkg::*; ();

        localparam int TIMEOUT_CYCLES = 200;

        logic                      gtwiz_buffbypass_tx_clk_in;
        logic                      gtwiz_buffbypass_tx_reset_in;
        logic                      resetdone;
        logic                      start_user;
        tx_lane_stat_t             lane_stat [C_NUM_CHANNELS];
        tx_lane_ctrl_t             lane_ctrl [C_NUM_CHANNELS];
        buffbypass_status_t        status;
        logic                      withhold_master_phaligndone;
        logic [C_NUM_CHANNELS-1:0] lane_force_low;

        int   error_count      = 0;
        int   timeout_count    = 0;
        int   srst_pulse_count = 0;
        logic srst_prev        = 1'b0;

        initial begin
                gtwiz_buffbypass_tx_clk_in = 1'b0;
                forever begin
                        #50 gtwiz_buffbypass_tx_clk_in = ~gtwiz_buffbypass_tx_clk_in;
                end
        end

        buffbypass_tx_top UUT (
                .gtwiz_buffbypass_tx_clk_in   (gtwiz_buffbypass_tx_clk_in),
                .gtwiz_buffbypass_tx_reset_in (gtwiz_buffbypass_tx_reset_in),
                .resetdone                    (resetdone),
                .start_user                   (start_user),
                .lane_stat                    (lane_stat),
                .lane_ctrl                    (lane_ctrl),
                .status                       (status)
        );

        gt_txphase_model u_gt_model (
                .clk                         (gtwiz_buffbypass_tx_clk_in),
                .lane_ctrl                   (lane_ctrl),
                .withhold_master_phaligndone (withhold_master_phaligndone),
                .lane_force_low              (lane_force_low),
                .lane_stat                   (lane_stat)
        );

        // A finished run always reports done, and an error exactly when alignment was withheld
        function automatic buffbypass_status_t expected_status(input logic withheld);
                buffbypass_status_t exp_st;
                exp_st.done  = 1'b1;
                exp_st.error = withheld;
                return exp_st;
        endfunction

        task automatic report_mismatch(input string msg);
                error_count++;
                $display("FAILED at %0t ns: %s", $time, msg);
        endtask

        // Counts dlysreset pulses and flags any pulse wider than one cycle
        always @(posedge gtwiz_buffbypass_tx_clk_in) begin
                if (gtwiz_buffbypass_tx_reset_in) begin
                        srst_prev <= 1'b0;
                end else begin
                        for (int li = 0; li < C_NUM_CHANNELS; li++) begin
                                if (lane_ctrl[li].dlysreset !== lane_ctrl[0].dlysreset) begin
                                        report_mismatch($sformatf("dlysreset of lane %0d differs", li));
                                end
                                if (lane_ctrl[li].syncmode !== (li == C_MASTER_CHANNEL)) begin
                                        report_mismatch($sformatf("syncmode of lane %0d wrong", li));
                                end
                        end
                        if (lane_ctrl[0].dlysreset && !srst_prev) begin
                                srst_pulse_count++;
                        end
                        if (lane_ctrl[0].dlysreset && srst_prev) begin
                                report_mismatch("dlysreset held high for more than one cycle");
                        end
                        srst_prev <= lane_ctrl[0].dlysreset;
                end
        end

        task automatic wait_for_dlysreset(output bit seen);
                int cycles;
                cycles = 0;
                seen   = 1'b0;
                while (!seen && cycles < TIMEOUT_CYCLES) begin
                        @(negedge gtwiz_buffbypass_tx_clk_in);
                        cycles++;
                        seen = lane_ctrl[0].dlysreset;
                end
                if (!seen) begin
                        timeout_count++;
                        $display("No dlysreset pulse appeared within %0d cycles", TIMEOUT_CYCLES);
                end
        endtask

        task automatic wait_for_done(output bit seen);
                int cycles;
                cycles = 0;
                seen   = 1'b0;
                while (!seen && cycles < TIMEOUT_CYCLES) begin
                        @(negedge gtwiz_buffbypass_tx_clk_in);
                        cycles++;
                        seen = status.done;
                end
                if (!seen) begin
                        timeout_count++;
                        $display("The bypass procedure never reported done within %0d cycles",
                                 TIMEOUT_CYCLES);
                end
        endtask

        task automatic check_reset_state();
                tx_lane_ctrl_t exp_ctrl;
                tx_lane_ctrl_t got_ctrl;
                if (status !== '0) begin
                        report_mismatch($sformatf("status %b after reset", status));
                end
                for (int li = 0; li < C_NUM_CHANNELS; li++) begin
                        exp_ctrl          = '0;
                        exp_ctrl.syncmode = (li == C_MASTER_CHANNEL);
                        got_ctrl          = lane_ctrl[li];
                        // Cross-connected bits follow the transceiver and are checked apart
                        got_ctrl.syncallin = 1'b0;
                        got_ctrl.syncin    = 1'b0;
                        if (got_ctrl !== exp_ctrl) begin
                                report_mismatch($sformatf("lane %0d controls %h, expected %h",
                                                          li, got_ctrl, exp_ctrl));
                        end
                end
        endtask

        task automatic check_cross_connect();
                logic exp_allin;
                logic exp_syncin;
                exp_allin  = 1'b1;
                exp_syncin = lane_stat[C_MASTER_CHANNEL].syncout;
                for (int li = 0; li < C_NUM_CHANNELS; li++) begin
                        exp_allin &= lane_stat[li].phaligndone;
                end
                for (int li = 0; li < C_NUM_CHANNELS; li++) begin
                        if (lane_ctrl[li].syncallin !== exp_allin) begin
                                report_mismatch($sformatf("syncallin of lane %0d is %b", li,
                                                          lane_ctrl[li].syncallin));
                        end
                        if (lane_ctrl[li].syncin !== exp_syncin) begin
                                report_mismatch($sformatf("syncin of lane %0d is %b", li,
                                                          lane_ctrl[li].syncin));
                        end
                end
        endtask

        // Strobe lands on one rising edge and the check runs one cycle after it
        task automatic strobe_start_and_check();
                start_user = 1'b1;
                @(negedge gtwiz_buffbypass_tx_clk_in);
                start_user = 1'b0;
                if (lane_ctrl[0].dlysreset !== 1'b1) begin
                        report_mismatch("start_user did not raise dlysreset");
                end
                if (status.done !== 1'b0) begin
                        report_mismatch("done not cleared one cycle after start_user");
                end
                @(negedge gtwiz_buffbypass_tx_clk_in);
                if (lane_ctrl[0].dlysreset !== 1'b0) begin
                        report_mismatch("dlysreset still high a cycle after the pulse");
                end
        endtask

        initial begin
                bit seen;
                int pulses_before;
                gtwiz_buffbypass_tx_reset_in = 1'b1;
                resetdone                    = 1'b0;
                start_user                   = 1'b0;
                withhold_master_phaligndone  = 1'b0;
                lane_force_low               = '0;
                repeat (4) @(posedge gtwiz_buffbypass_tx_clk_in);
                @(negedge gtwiz_buffbypass_tx_clk_in);
                gtwiz_buffbypass_tx_reset_in = 1'b0;
                @(negedge gtwiz_buffbypass_tx_clk_in);
                check_reset_state();
                check_cross_connect();

                // Transceiver reset completes and kicks off the first run
                resetdone = 1'b1;
                wait_for_dlysreset(seen);
                if (seen) begin
                        @(negedge gtwiz_buffbypass_tx_clk_in);
                        if (lane_ctrl[0].dlysreset !== 1'b0) begin
                                report_mismatch("dlysreset after reset-done wider than one cycle");
                        end
                end
                wait_for_done(seen);
                if (seen) begin
                        if (status !== expected_status(withhold_master_phaligndone)) begin
                                report_mismatch($sformatf("status %b after first run", status));
                        end
                end
                check_cross_connect();

                // Pull each lane low in turn and watch the shared sync inputs follow
                for (int li = 0; li < C_NUM_CHANNELS; li++) begin
                        lane_force_low     = '0;
                        lane_force_low[li] = 1'b1;
                        @(negedge gtwiz_buffbypass_tx_clk_in);
                        check_cross_connect();
                        lane_force_low = '0;
                        @(negedge gtwiz_buffbypass_tx_clk_in);
                        check_cross_connect();
                end
                // Let the master sync-done edge from the release drain through the synchronizer
                repeat (2 * C_SYNC_STAGES) @(negedge gtwiz_buffbypass_tx_clk_in);

                // Master lane never aligns, so the run must end in error
                withhold_master_phaligndone = 1'b1;
                strobe_start_and_check();
                wait_for_done(seen);
                if (seen) begin
                        if (status !== expected_status(withhold_master_phaligndone)) begin
                                report_mismatch($sformatf("status %b with alignment withheld",
                                                          status));
                        end
                end
                check_cross_connect();

                // A second strobe during the wait for sync-done is ignored
                withhold_master_phaligndone = 1'b0;
                pulses_before = srst_pulse_count;
                strobe_start_and_check();
                @(negedge gtwiz_buffbypass_tx_clk_in);
                if (status.done !== 1'b0) begin
                        report_mismatch("done high while the procedure should still wait");
                end
                start_user = 1'b1;
                @(negedge gtwiz_buffbypass_tx_clk_in);
                start_user = 1'b0;
                if (lane_ctrl[0].dlysreset !== 1'b0) begin
                        report_mismatch("start_user during the wait raised dlysreset");
                end
                wait_for_done(seen);
                if (seen) begin
                        if (status !== expected_status(withhold_master_phaligndone)) begin
                                report_mismatch($sformatf("status %b after last run", status));
                        end
                end
                @(negedge gtwiz_buffbypass_tx_clk_in);
                if (srst_pulse_count - pulses_before != 1) begin
                        report_mismatch($sformatf("%0d dlysreset pulses in last run, expected 1",
                                                  srst_pulse_count - pulses_before));
                end

                $display("Summary: %0d errors, %0d timeouts", error_count, timeout_count);
                if (error_count == 0 && timeout_count == 0) begin
                        $display("=== PASS ===");
                end else begin
                        $display("=== FAIL ===");
                end
                $finish;
        end

endmodule
